/* filelist.f */
common/spi_bridge_pkg.sv
spi/spi_trx.sv
spi/spi_frame_ctrl.sv
design/reg_bank.sv
design/gpio_port.sv
design/wb_slave_mux.sv
design/spi_bridge_top.sv
sim/tb_spi_bridge.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_spi_bridge -f filelist.f || exit 1
out=$(./obj_dir/Vtb_spi_bridge)
echo "$out"
echo "$out" | grep -qx "TESTS PASSED" && exit 0 || exit 1

/* sim/tb_spi_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_spi_bridge;

    import spi_bridge_pkg::*;

    localparam int REG_COUNT  = 16;
    localparam int GPIO_WIDTH = 8;
    localparam int HALF_CLKS  = 10;
    localparam int GAP_CLKS   = 20;
    // about 60 bytes of 16 half periods, plus reset and frame gaps, doubled.
    localparam int EST_BYTES  = 60;
    localparam int MAX_CYCLES = 2 * (EST_BYTES * 16 * HALF_CLKS + 400);

    logic                  clk = 1'b0;
    logic                  rst_i;
    logic                  sck_i;
    logic                  mosi_i;
    logic                  ss_i;
    wire                   miso_o;
    logic [GPIO_WIDTH-1:0] gpio_i;
    wire  [GPIO_WIDTH-1:0] gpio_o;

    byte_t                 tx_buf [64];
    byte_t                 rx_buf [64];
    byte_t                 model_mem [128];
    logic [GPIO_WIDTH-1:0] exp_gpio_o;
    logic [31:0]           lfsr_q = 32'hbc69_f88e;
    int                    error_cnt = 0;
    int                    check_cnt = 0;
    int                    test_cnt = 0;
    int                    failed_tests = 0;
    int                    test_err_start = 0;
    int                    cycle_cnt = 0;

    spi_bridge_top #(
        .REG_COUNT  (REG_COUNT),
        .GPIO_WIDTH (GPIO_WIDTH)
    ) i_spi_bridge_top (
        .clk    (clk),
        .rst_i  (rst_i),
        .sck_i  (sck_i),
        .mosi_i (mosi_i),
        .ss_i   (ss_i),
        .miso_o (miso_o),
        .gpio_i (gpio_i),
        .gpio_o (gpio_o)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // between frames the gpio output must match the mirrored register.
    gpio_matches_model_a: assert property (
        @(posedge clk) disable iff (rst_i || !ss_i) gpio_o == exp_gpio_o
    ) else begin
        $display("CHECK FAILED gpio_o: got 0x%02h, expected 0x%02h", gpio_o, exp_gpio_o);
        error_cnt++;
    end

    // galois form of x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // bank and gpio output take writes, everything else drops them.
    task automatic update_model(input addr_t a, input byte_t d);
        if (int'(a) < REG_COUNT) begin
            model_mem[a] = d;
        end else if (a == GPIO_OUT_ADDR) begin
            model_mem[a] = d;
            exp_gpio_o = d[GPIO_WIDTH-1:0];
        end
    endtask

    function automatic byte_t expected_read(input addr_t a);
        if (int'(a) < REG_COUNT || a == GPIO_OUT_ADDR) begin
            return model_mem[a];
        end
        if (a == GPIO_IN_ADDR) begin
            return byte_t'(gpio_i);
        end
        return 8'hff;
    endfunction

    task automatic check_byte(input string sig, input byte_t got, input byte_t expected);
        check_cnt++;
        assert (got == expected) else begin
            $display("CHECK FAILED %s: got 0x%02h, expected 0x%02h", sig, got, expected);
            error_cnt++;
        end
    endtask

    task automatic check_gpio();
        check_cnt++;
        assert (gpio_o == exp_gpio_o) else begin
            $display("CHECK FAILED gpio_o: got 0x%02h, expected 0x%02h", gpio_o, exp_gpio_o);
            error_cnt++;
        end
    endtask

    // mode 0 frame, msb first; miso is taken just before each rising sck.
    task automatic spi_frame(input int nbytes);
        ss_i = 1'b0;
        wait_cycles(HALF_CLKS);
        for (int b = 0; b < nbytes; b++) begin
            for (int i = 7; i >= 0; i--) begin
                mosi_i = tx_buf[b][i];
                wait_cycles(HALF_CLKS);
                rx_buf[b][i] = miso_o;
                sck_i = 1'b1;
                wait_cycles(HALF_CLKS);
                sck_i = 1'b0;
            end
        end
        wait_cycles(HALF_CLKS);
        ss_i = 1'b1;
        mosi_i = 1'b0;
        wait_cycles(GAP_CLKS);
    endtask

    // payload sits in tx_buf[1..n].
    task automatic write_frame(input addr_t start, input int n);
        tx_buf[0] = {1'b1, start};
        for (int i = 0; i < n; i++) begin
            update_model(start + addr_t'(i), tx_buf[1 + i]);
        end
        // model changes in the same step that ss falls.
        spi_frame(n + 1);
    endtask

    task automatic read_check(input addr_t start, input int n);
        addr_t a;
        tx_buf[0] = {1'b0, start};
        for (int i = 1; i <= n; i++) begin
            tx_buf[i] = 8'h00;
        end
        spi_frame(n + 1);
        for (int i = 0; i < n; i++) begin
            a = start + addr_t'(i);
            check_byte($sformatf("miso_o at 0x%02h", a), rx_buf[i + 1], expected_read(a));
        end
    endtask

    task automatic start_test();
        test_err_start = error_cnt;
    endtask

    task automatic end_test(input string name);
        test_cnt++;
        if (error_cnt == test_err_start) begin
            $display("test %0d %s: ok", test_cnt, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: %0d error(s)", test_cnt, name, error_cnt - test_err_start);
        end
    endtask

    initial begin
        logic [31:0] r;
        addr_t       a;
        rst_i = 1'b1;
        sck_i = 1'b0;
        mosi_i = 1'b0;
        ss_i = 1'b1;
        gpio_i = '0;
        exp_gpio_o = '0;
        for (int i = 0; i < 128; i++) begin
            model_mem[i] = 8'h00;
        end
        wait_cycles(10);
        rst_i = 1'b0;
        wait_cycles(5);

        start_test();
        read_check(REG_BASE, 1);
        read_check(GPIO_OUT_ADDR, 1);
        check_gpio();
        end_test("reset values");

        start_test();
        take_bits(4, r);
        a = addr_t'(r[3:0]);
        take_bits(8, r);
        tx_buf[1] = r[7:0];
        write_frame(a, 1);
        read_check(a, 1);
        end_test("single write and read");

        // start low enough that all four bytes stay inside the bank.
        start_test();
        take_bits(4, r);
        a = addr_t'(r[3:0] % 4'd13);
        for (int i = 0; i < 4; i++) begin
            take_bits(8, r);
            tx_buf[1 + i] = r[7:0];
        end
        write_frame(a, 4);
        read_check(a, 4);
        end_test("burst write and read");

        start_test();
        take_bits(8, r);
        tx_buf[1] = r[7:0];
        write_frame(GPIO_OUT_ADDR, 1);
        check_gpio();
        read_check(GPIO_OUT_ADDR, 1);
        end_test("gpio output");

        start_test();
        take_bits(8, r);
        gpio_i = r[GPIO_WIDTH-1:0];
        read_check(GPIO_IN_ADDR, 1);
        end_test("gpio input");

        // one burst covers the bank, then gpio out and gpio in.
        start_test();
        read_check(7'h40, 1);
        take_bits(8, r);
        tx_buf[1] = r[7:0];
        write_frame(7'h40, 1);
        read_check(REG_BASE, REG_COUNT + 2);
        check_gpio();
        end_test("unmapped address");

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 test_cnt, failed_tests, check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/spi_bridge_top.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_bridge_top #(
    parameter int REG_COUNT  = 16,
    parameter int GPIO_WIDTH = 8
) (
    input  wire                   clk,
    input  wire                   rst_i,
    input  wire                   sck_i,
    input  wire                   mosi_i,
    input  wire                   ss_i,
    output logic                  miso_o,
    input  wire [GPIO_WIDTH-1:0]  gpio_i,
    output logic [GPIO_WIDTH-1:0] gpio_o
);

    import spi_bridge_pkg::*;

    logic  frame_start;
    byte_t rx_data;
    logic  rx_valid;
    byte_t tx_data;
    logic  tx_load;

    logic  wb_cyc;
    logic  wb_stb;
    logic  wb_we;
    addr_t wb_adr;
    byte_t wb_dat_w;
    byte_t wb_dat_r;
    logic  wb_ack;

    logic  reg_stb;
    logic  reg_ack;
    byte_t reg_dat;
    logic  gpio_stb;
    logic  gpio_ack;
    byte_t gpio_dat;

    spi_trx i_spi_trx (
        .clk           (clk),
        .rst_i         (rst_i),
        .sck_i         (sck_i),
        .mosi_i        (mosi_i),
        .ss_i          (ss_i),
        .tx_data_i     (tx_data),
        .tx_load_i     (tx_load),
        .miso_o        (miso_o),
        .frame_start_o (frame_start),
        .rx_data_o     (rx_data),
        .rx_valid_o    (rx_valid)
    );

    spi_frame_ctrl i_spi_frame_ctrl (
        .clk           (clk),
        .rst_i         (rst_i),
        .frame_start_i (frame_start),
        .rx_data_i     (rx_data),
        .rx_valid_i    (rx_valid),
        .wb_ack_i      (wb_ack),
        .wb_dat_i      (wb_dat_r),
        .tx_data_o     (tx_data),
        .tx_load_o     (tx_load),
        .wb_cyc_o      (wb_cyc),
        .wb_stb_o      (wb_stb),
        .wb_we_o       (wb_we),
        .wb_adr_o      (wb_adr),
        .wb_dat_o      (wb_dat_w)
    );

    wb_slave_mux #(
        .REG_COUNT (REG_COUNT)
    ) i_wb_slave_mux (
        .clk        (clk),
        .rst_i      (rst_i),
        .wb_cyc_i   (wb_cyc),
        .wb_stb_i   (wb_stb),
        .wb_adr_i   (wb_adr),
        .reg_ack_i  (reg_ack),
        .gpio_ack_i (gpio_ack),
        .reg_dat_i  (reg_dat),
        .gpio_dat_i (gpio_dat),
        .wb_ack_o   (wb_ack),
        .wb_dat_o   (wb_dat_r),
        .reg_stb_o  (reg_stb),
        .gpio_stb_o (gpio_stb)
    );

    reg_bank #(
        .REG_COUNT (REG_COUNT)
    ) i_reg_bank (
        .clk   (clk),
        .rst_i (rst_i),
        .stb_i (reg_stb),
        .we_i  (wb_we),
        .adr_i (wb_adr),
        .dat_i (wb_dat_w),
        .ack_o (reg_ack),
        .dat_o (reg_dat)
    );

    gpio_port #(
        .GPIO_WIDTH (GPIO_WIDTH)
    ) i_gpio_port (
        .clk    (clk),
        .rst_i  (rst_i),
        .stb_i  (gpio_stb),
        .we_i   (wb_we),
        .adr_i  (wb_adr),
        .dat_i  (wb_dat_w),
        .gpio_i (gpio_i),
        .ack_o  (gpio_ack),
        .dat_o  (gpio_dat),
        .gpio_o (gpio_o)
    );

endmodule

`default_nettype wire

/* design/wb_slave_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_slave_mux #(
    parameter int REG_COUNT = 16
) (
    input  wire                    clk,
    input  wire                    rst_i,
    input  wire                    wb_cyc_i,
    input  wire                    wb_stb_i,
    input  spi_bridge_pkg::addr_t  wb_adr_i,
    input  wire                    reg_ack_i,
    input  wire                    gpio_ack_i,
    input  spi_bridge_pkg::byte_t  reg_dat_i,
    input  spi_bridge_pkg::byte_t  gpio_dat_i,
    output logic                   wb_ack_o,
    output spi_bridge_pkg::byte_t  wb_dat_o,
    output logic                   reg_stb_o,
    output logic                   gpio_stb_o
);

    import spi_bridge_pkg::*;

    addr_t reg_off;
    logic  reg_sel;
    logic  gpio_sel;
    logic  none_sel;
    logic  req;
    logic  none_ack_q;

    // address decode.
    assign reg_off  = wb_adr_i - REG_BASE;
    assign reg_sel  = (reg_off < addr_t'(REG_COUNT));
    assign gpio_sel = (wb_adr_i == GPIO_OUT_ADDR) || (wb_adr_i == GPIO_IN_ADDR);
    assign none_sel = !reg_sel && !gpio_sel;

    assign req        = wb_cyc_i && wb_stb_i;
    assign reg_stb_o  = req && reg_sel;
    assign gpio_stb_o = req && gpio_sel;

    // the mux answers for holes in the map itself, with the same latency.
    always_ff @(posedge clk) begin
        if (rst_i) begin
            none_ack_q <= 1'b0;
        end else begin
            none_ack_q <= req && none_sel && !none_ack_q;
        end
    end

    assign wb_ack_o = reg_ack_i || gpio_ack_i || none_ack_q;

    always_comb begin
        if (reg_ack_i) begin
            wb_dat_o = reg_dat_i;
        end else if (gpio_ack_i) begin
            wb_dat_o = gpio_dat_i;
        end else begin
            wb_dat_o = NO_DEVICE_DATA;
        end
    end

    one_slave_stb_a: assert property (
        @(posedge clk) disable iff (rst_i) !(reg_stb_o && gpio_stb_o)
    );

    // responses from the slaves and the mux never overlap.
    one_ack_a: assert property (
        @(posedge clk) disable iff (rst_i) $onehot0({reg_ack_i, gpio_ack_i, none_ack_q})
    );

endmodule

`default_nettype wire

/* design/gpio_port.sv */
`timescale 1ns/1ps
`default_nettype none

module gpio_port #(
    parameter int GPIO_WIDTH = 8
) (
    input  wire                    clk,
    input  wire                    rst_i,
    input  wire                    stb_i,
    input  wire                    we_i,
    input  spi_bridge_pkg::addr_t  adr_i,
    input  spi_bridge_pkg::byte_t  dat_i,
    input  wire [GPIO_WIDTH-1:0]   gpio_i,
    output logic                   ack_o,
    output spi_bridge_pkg::byte_t  dat_o,
    output logic [GPIO_WIDTH-1:0]  gpio_o
);

    import spi_bridge_pkg::*;

    logic [GPIO_WIDTH-1:0] out_q;
    logic [GPIO_WIDTH-1:0] in_meta_q;
    logic [GPIO_WIDTH-1:0] in_sync_q;
    logic                  sel_in;

    // bit 0 separates the output register from the input register.
    assign sel_in = adr_i[0];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            out_q <= '0;
        end else if (stb_i && we_i && !sel_in && !ack_o) begin
            out_q <= dat_i[GPIO_WIDTH-1:0];
        end
    end

    assign gpio_o = out_q;

    // two-flop synchronizer for the external inputs.
    always_ff @(posedge clk) begin
        if (rst_i) begin
            in_meta_q <= '0;
            in_sync_q <= '0;
        end else begin
            in_meta_q <= gpio_i;
            in_sync_q <= in_meta_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= stb_i && !ack_o;
        end
    end

    always_ff @(posedge clk) begin
        if (stb_i) begin
            dat_o <= sel_in ? byte_t'(in_sync_q) : byte_t'(out_q);
        end
    end

endmodule

`default_nettype wire

/* design/reg_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_bank #(
    parameter int REG_COUNT = 16
) (
    input  wire                    clk,
    input  wire                    rst_i,
    input  wire                    stb_i,
    input  wire                    we_i,
    input  spi_bridge_pkg::addr_t  adr_i,
    input  spi_bridge_pkg::byte_t  dat_i,
    output logic                   ack_o,
    output spi_bridge_pkg::byte_t  dat_o
);

    import spi_bridge_pkg::*;

    localparam int IDX_W = (REG_COUNT > 1) ? $clog2(REG_COUNT) : 1;

    byte_t             regs_q [REG_COUNT];
    logic [IDX_W-1:0]  idx;

    // only the low bits pick a register; the mux has already decoded the rest.
    assign idx = adr_i[IDX_W-1:0];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs_q[i] <= '0;
            end
        end else if (stb_i && we_i && !ack_o) begin
            regs_q[idx] <= dat_i;
        end
    end

    // single-cycle ack, dropped while the master releases stb.
    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= stb_i && !ack_o;
        end
    end

    always_ff @(posedge clk) begin
        if (stb_i) begin
            dat_o <= regs_q[idx];
        end
    end

endmodule

`default_nettype wire

/* spi/spi_frame_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_frame_ctrl (
    input  wire                    clk,
    input  wire                    rst_i,
    input  wire                    frame_start_i,
    input  spi_bridge_pkg::byte_t  rx_data_i,
    input  wire                    rx_valid_i,
    input  wire                    wb_ack_i,
    input  spi_bridge_pkg::byte_t  wb_dat_i,
    output spi_bridge_pkg::byte_t  tx_data_o,
    output logic                   tx_load_o,
    output logic                   wb_cyc_o,
    output logic                   wb_stb_o,
    output logic                   wb_we_o,
    output spi_bridge_pkg::addr_t  wb_adr_o,
    output spi_bridge_pkg::byte_t  wb_dat_o
);

    import spi_bridge_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CMD,
        ST_DATA,
        ST_BUS_WAIT
    } state_t;

    state_t state_q;
    logic   write_mode_q;
    addr_t  adr_q;
    byte_t  dat_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q      <= ST_IDLE;
            write_mode_q <= 1'b0;
            adr_q        <= '0;
            wb_cyc_o     <= 1'b0;
            wb_stb_o     <= 1'b0;
            wb_we_o      <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (frame_start_i) begin
                        state_q <= ST_CMD;
                    end
                end

                ST_CMD: begin
                    if (frame_start_i) begin
                        state_q <= ST_CMD;
                    end else if (rx_valid_i) begin
                        write_mode_q <= rx_data_i[7];
                        adr_q        <= rx_data_i[6:0];
                        if (rx_data_i[7]) begin
                            state_q <= ST_DATA;
                        end else begin
                            // a read frame fetches the start address right away.
                            wb_cyc_o <= 1'b1;
                            wb_stb_o <= 1'b1;
                            wb_we_o  <= 1'b0;
                            state_q  <= ST_BUS_WAIT;
                        end
                    end
                end

                ST_DATA: begin
                    if (frame_start_i) begin
                        state_q <= ST_CMD;
                    end else if (rx_valid_i) begin
                        // each byte costs exactly one bus access.
                        wb_cyc_o <= 1'b1;
                        wb_stb_o <= 1'b1;
                        wb_we_o  <= write_mode_q;
                        state_q  <= ST_BUS_WAIT;
                    end
                end

                ST_BUS_WAIT: begin
                    // the access always finishes, even across a new frame.
                    if (wb_ack_i) begin
                        wb_cyc_o <= 1'b0;
                        wb_stb_o <= 1'b0;
                        wb_we_o  <= 1'b0;
                        adr_q    <= adr_q + addr_t'(1);
                        state_q  <= frame_start_i ? ST_CMD : ST_DATA;
                    end
                end

                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // write payload.
    always_ff @(posedge clk) begin
        if (state_q == ST_DATA && rx_valid_i) begin
            dat_q <= rx_data_i;
        end
    end

    assign wb_adr_o = adr_q;
    assign wb_dat_o = dat_q;

    // read data is handed to the transceiver in the ack cycle.
    assign tx_load_o = (state_q == ST_BUS_WAIT) && wb_ack_i && !wb_we_o;
    assign tx_data_o = wb_dat_i;

    stb_inside_cyc_a: assert property (
        @(posedge clk) disable iff (rst_i) $rose(wb_stb_o) |-> wb_cyc_o
    );

endmodule

`default_nettype wire

/* spi/spi_trx.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_trx (
    input  wire                    clk,
    input  wire                    rst_i,
    input  wire                    sck_i,
    input  wire                    mosi_i,
    input  wire                    ss_i,
    input  spi_bridge_pkg::byte_t  tx_data_i,
    input  wire                    tx_load_i,
    output logic                   miso_o,
    output logic                   frame_start_o,
    output spi_bridge_pkg::byte_t  rx_data_o,
    output logic                   rx_valid_o
);

    import spi_bridge_pkg::*;

    logic [1:0] sck_hist_q;
    logic [1:0] ss_hist_q;
    logic       mosi_q;
    logic       ss_negedge;
    logic       ss_active;
    logic       sck_posedge;
    logic       sck_negedge;
    logic [2:0] pos_cnt_q;
    logic [2:0] neg_cnt_q;
    logic       pos_eighth;
    logic       pos_eighth_q;
    logic       neg_eighth;
    byte_t      rx_shift_q;
    byte_t      tx_latch_q;
    byte_t      tx_shift_q;

    // two-flop history of sck and ss, idle levels on reset.
    always_ff @(posedge clk) begin
        if (rst_i) begin
            sck_hist_q <= 2'b00;
            ss_hist_q  <= 2'b11;
        end else begin
            sck_hist_q <= {sck_hist_q[0], sck_i};
            ss_hist_q  <= {ss_hist_q[0], ss_i};
        end
    end

    // mosi is delayed one flop to line up with the sck edge detect.
    always_ff @(posedge clk) begin
        mosi_q <= mosi_i;
    end

    assign ss_negedge  = (ss_hist_q == 2'b10);
    assign ss_active   = ~ss_hist_q[0];
    assign sck_posedge = ss_active && (sck_hist_q == 2'b01);
    assign sck_negedge = ss_active && (sck_hist_q == 2'b10);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            frame_start_o <= 1'b0;
        end else begin
            frame_start_o <= ss_negedge;
        end
    end

    // receive side, msb first.
    always_ff @(posedge clk) begin
        if (sck_posedge) begin
            rx_shift_q <= {rx_shift_q[6:0], mosi_q};
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i || ss_negedge) begin
            pos_cnt_q <= 3'd0;
        end else if (sck_posedge) begin
            pos_cnt_q <= pos_cnt_q + 3'd1;
        end
    end

    assign pos_eighth = sck_posedge && (pos_cnt_q == 3'd7);

    // the shift register holds the full byte one cycle after the eighth edge.
    always_ff @(posedge clk) begin
        if (rst_i) begin
            pos_eighth_q <= 1'b0;
            rx_valid_o   <= 1'b0;
        end else begin
            pos_eighth_q <= pos_eighth;
            rx_valid_o   <= pos_eighth_q;
        end
    end

    always_ff @(posedge clk) begin
        if (pos_eighth_q) begin
            rx_data_o <= rx_shift_q;
        end
    end

    // transmit side.
    always_ff @(posedge clk) begin
        if (rst_i || ss_negedge) begin
            neg_cnt_q <= 3'd0;
        end else if (sck_negedge) begin
            neg_cnt_q <= neg_cnt_q + 3'd1;
        end
    end

    assign neg_eighth = sck_negedge && (neg_cnt_q == 3'd7);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            tx_latch_q <= '0;
        end else if (tx_load_i) begin
            tx_latch_q <= tx_data_i;
        end
    end

    // reload the next reply at frame start and at each byte boundary.
    always_ff @(posedge clk) begin
        if (rst_i) begin
            tx_shift_q <= '0;
        end else if (ss_negedge || neg_eighth) begin
            tx_shift_q <= tx_latch_q;
        end else if (sck_negedge) begin
            tx_shift_q <= {tx_shift_q[6:0], 1'b0};
        end
    end

    assign miso_o = tx_shift_q[7];

    rx_valid_single_a: assert property (
        @(posedge clk) disable iff (rst_i) rx_valid_o |=> !rx_valid_o
    );

endmodule

`default_nettype wire

/* common/spi_bridge_pkg.sv */
`default_nettype none

package spi_bridge_pkg;

    // one data byte on spi and on the wishbone side.
    typedef logic [7:0] byte_t;

    // register address carried in the low bits of the command byte.
    typedef logic [6:0] addr_t;

    // the bank starts at the bottom of the map.
    localparam addr_t REG_BASE = 7'h00;

    // gpio output register, read and write.
    localparam addr_t GPIO_OUT_ADDR = 7'h10;

    // gpio input register, read only.
    localparam addr_t GPIO_IN_ADDR = 7'h11;

    // returned when nothing answers at an address.
    localparam byte_t NO_DEVICE_DATA = 8'hff;

endpackage

`default_nettype wire
